// File: flist.f
logic/bp_cfg_pkg.sv
logic/bp_types_pkg.sv
logic/bp_update_if.sv
logic/bp_init_sweep.sv
logic/bp_update_fsm.sv
logic/bht_table.sv
logic/btb_table.sv
logic/branch_predictor.sv
dv/branch_predictor_tb.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - files:
      - logic/bp_cfg_pkg.sv
      - logic/bp_types_pkg.sv
      - logic/bp_update_if.sv
      - logic/bp_init_sweep.sv
      - logic/bp_update_fsm.sv
      - logic/bht_table.sv
      - logic/btb_table.sv
      - logic/branch_predictor.sv
  - target: test
    files:
      - dv/branch_predictor_tb.sv

// File: dv/bp_trace.txt
# L pc exp_taken exp_hit exp_target  (target only compared when exp_hit is 1)
# U pc taken target exp_mispredict   (all fields hex)
L 00001040 0 0 00000000
L 0000abcc 0 0 00000000
U 00001040 1 00002000 1
L 00001040 0 1 00002000
U 00001040 1 00002000 1
L 00001040 1 1 00002000
U 00001040 0 00000000 1
L 00001040 0 1 00002000
U 00001040 1 00002000 1
U 00001040 1 00003000 1
L 00001040 1 1 00003000
U 00001040 1 00003000 0
L 00002040 0 0 00000000
U 00002040 0 00000000 0
L 00001040 1 1 00003000
U 00002040 0 00000000 0
L 00001040 0 1 00003000
U 00002040 1 00004000 1
L 00002042 1 1 00004000
L 00001040 0 0 00000000
U 00000100 0 00000000 0
L 00000100 0 0 00000000

// File: dv/branch_predictor_tb.sv
// branch predictor testbench
// replays fetch lookups and four-phase updates from the trace file,
// checking every response against the expected columns
module branch_predictor_tb;

    localparam int sweep_cycles = 64;  // default entries, one clear per cycle

    logic        clk;
    logic        rst;
    logic [31:0] fetch_pc;
    logic        upd_req;
    logic [31:0] upd_pc;
    logic        upd_taken;
    logic [31:0] upd_target;
    logic        pred_taken;
    logic        pred_hit;
    logic [31:0] pred_target;
    logic        upd_ack;
    logic        upd_mispredict;
    logic        ready;

    integer      seed;
    integer      fd;
    integer      ch;
    integer      nfields;
    integer      gap;
    int          n_ops;
    int          ops_done;
    int          cycle_cnt;
    int          cycle_limit;  // 0 until the trace is counted
    logic [31:0] f_pc;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_c;

    branch_predictor u_branch_predictor (
        .clk, .rst, .fetch_pc, .upd_req, .upd_pc, .upd_taken, .upd_target,
        .pred_taken, .pred_hit, .pred_target, .upd_ack, .upd_mispredict, .ready
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout, run went past %0d cycles", cycle_limit));
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin  // X counts as a mismatch
            abort_run($sformatf("** Error at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // op lines start with L or U
    task automatic count_ops(input integer fh, output int cnt);
        integer c;
        logic   at_start;
        cnt = 0;
        at_start = 1'b1;
        c = $fgetc(fh);
        while (c != -1) begin
            if (at_start && (c == "L" || c == "U")) cnt++;
            at_start = (c == "\n");
            c = $fgetc(fh);
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ready !== 1'b1) begin
            check_val("pred_hit", pred_hit, 1'b0);  // gated during sweep
            check_val("pred_taken", pred_taken, 1'b0);
            cycles++;
            @(negedge clk);
        end
        check_val("ready_delay", cycles, sweep_cycles);  // counted from rst release edge
    endtask

    task automatic do_lookup(input logic [31:0] pc, input logic exp_taken,
                             input logic exp_hit, input logic [31:0] exp_tgt);
        @(posedge clk);
        fetch_pc <= pc;
        @(negedge clk);  // combinational path settled
        check_val("pred_hit", pred_hit, exp_hit);
        check_val("pred_taken", pred_taken, exp_taken);
        if (exp_hit) check_val("pred_target", pred_target, exp_tgt);
    endtask

    task automatic do_update(input logic [31:0] pc, input logic tk,
                             input logic [31:0] tgt, input logic exp_mp);
        int waits;
        @(negedge clk);
        check_val("upd_ack", upd_ack, 1'b0);  // previous handshake closed
        @(posedge clk);
        upd_req    <= 1'b1;
        upd_pc     <= pc;
        upd_taken  <= tk;
        upd_target <= tgt;
        waits = 1;
        @(negedge clk);
        while (upd_ack !== 1'b1) begin
            waits++;
            @(negedge clk);
        end
        // 3 cycles after the edge that first sees upd_req, plus the driving edge
        check_val("upd_ack_delay", waits, 4);
        check_val("upd_mispredict", upd_mispredict, exp_mp);
        @(posedge clk);
        upd_req <= 1'b0;
        @(negedge clk);
        check_val("upd_ack", upd_ack, 1'b1);  // req drop not seen yet
        check_val("upd_mispredict", upd_mispredict, exp_mp);
        waits = 0;
        while (upd_ack !== 1'b0) begin
            waits++;
            @(negedge clk);
        end
        check_val("upd_ack_release", waits, 1);
    endtask

    initial begin
        seed        = 32'h810a;
        cycle_cnt   = 0;
        cycle_limit = 0;
        ops_done    = 0;
        rst         = 1'b1;
        fetch_pc    = 32'h0000_1040;
        upd_req     = 1'b0;
        upd_pc      = '0;
        upd_taken   = 1'b0;
        upd_target  = '0;

        fd = $fopen("dv/bp_trace.txt", "r");
        if (fd == 0) abort_run("could not open trace file dv/bp_trace.txt");
        count_ops(fd, n_ops);
        $fclose(fd);
        cycle_limit = 64 + 12 * n_ops + 200;
        fd = $fopen("dv/bp_trace.txt", "r");

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        wait_ready();

        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin  // comment runs to end of line
                while (ch != "\n" && ch != -1) ch = $fgetc(fd);
            end else if (ch == "L" || ch == "U") begin
                nfields = $fscanf(fd, "%h %h %h %h", f_pc, f_a, f_b, f_c);
                if (nfields != 4) abort_run("trace line is missing fields");
                if (ch == "L") do_lookup(f_pc, f_a[0], f_b[0], f_c);
                else do_update(f_pc, f_a[0], f_b, f_c[0]);
                ops_done++;
                gap = $unsigned($random(seed)) % 4;  // idle 0..3 cycles
                repeat (gap) @(posedge clk);
            end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
                abort_run("trace line starts with an unknown operation");
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);

        if (ops_done == 0) begin
            abort_run("trace file held no operations");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: logic/branch_predictor.sv
// branch predictor top
// bht + btb with a same-cycle fetch lookup and a four-phase
// resolved-branch update port
module branch_predictor #(
    parameter int entries  = 64,
    parameter int tag_bits = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [bp_cfg_pkg::pc_width-1:0] fetch_pc,
    input  logic                            upd_req,
    input  logic [bp_cfg_pkg::pc_width-1:0] upd_pc,
    input  logic                            upd_taken,
    input  logic [bp_cfg_pkg::pc_width-1:0] upd_target,
    output logic                            pred_taken,
    output logic                            pred_hit,
    output logic [bp_cfg_pkg::pc_width-1:0] pred_target,
    output logic                            upd_ack,
    output logic                            upd_mispredict,
    output logic                            ready
);
    import bp_types_pkg::*;

    bp_pc_u                     fetch_pc_u;
    logic                       pred_dir;
    logic                       clr_en;
    logic [$clog2(entries)-1:0] clr_index;

    bp_update_if upd_bus ();  // sequencer to both tables

    assign fetch_pc_u.raw = fetch_pc;

    bp_init_sweep #(.entries(entries)) u_init_sweep (
        .clk, .rst, .ready, .clr_en, .clr_index
    );

    bp_update_fsm u_update_fsm (
        .clk, .rst, .ready, .upd_req, .upd_pc, .upd_taken, .upd_target,
        .upd_ack, .upd_mispredict, .upd(upd_bus.seq)
    );

    bht_table #(.entries(entries)) u_bht (
        .clk, .rst, .fetch_pc(fetch_pc_u), .ready, .clr_en, .clr_index,
        .pred_dir, .upd(upd_bus.tbl)
    );

    btb_table #(.entries(entries), .tag_bits(tag_bits)) u_btb (
        .clk, .rst, .fetch_pc(fetch_pc_u), .ready, .clr_en, .clr_index,
        .pred_hit, .pred_target, .upd(upd_bus.tbl)
    );

    // taken only with a target to jump to
    assign pred_taken = pred_dir & pred_hit;

endmodule

// File: logic/btb_table.sv
// branch target buffer
// direct-mapped valid/tag/target arrays, allocates on taken branches,
// invalidated entry by entry by the init sweep
module btb_table #(
    parameter int entries  = 64,
    parameter int tag_bits = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  bp_types_pkg::bp_pc_u            fetch_pc,
    input  logic                            ready,
    input  logic                            clr_en,
    input  logic [$clog2(entries)-1:0]      clr_index,
    output logic                            pred_hit,
    output logic [bp_cfg_pkg::pc_width-1:0] pred_target,
    bp_update_if.tbl                        upd
);
    import bp_cfg_pkg::*;

    localparam int idx_bits = $clog2(entries);

    logic                valid_mem [entries];
    logic [tag_bits-1:0] tag_mem   [entries];
    logic [pc_width-1:0] tgt_mem   [entries];
    logic [idx_bits-1:0] fetch_idx;
    logic [idx_bits-1:0] upd_idx;
    logic [tag_bits-1:0] fetch_tag;
    logic [tag_bits-1:0] upd_tag;
    logic                alloc;

    // tag sits right above the index in the word address
    assign fetch_idx = fetch_pc.fields.waddr[idx_bits-1:0];
    assign fetch_tag = fetch_pc.fields.waddr[idx_bits +: tag_bits];
    assign upd_idx   = upd.pc.fields.waddr[idx_bits-1:0];
    assign upd_tag   = upd.pc.fields.waddr[idx_bits +: tag_bits];

    assign pred_hit    = ready & valid_mem[fetch_idx] & (tag_mem[fetch_idx] == fetch_tag);
    assign pred_target = tgt_mem[fetch_idx];

    assign upd.rd_hit    = valid_mem[upd_idx] & (tag_mem[upd_idx] == upd_tag);
    assign upd.rd_target = tgt_mem[upd_idx];

    assign alloc = upd.wr_en & upd.taken;  // not-taken leaves the entry alone

    always_ff @(posedge clk) begin
        if (!rst) begin
            if (clr_en) begin
                valid_mem[clr_index] <= 1'b0;
            end else if (alloc) begin
                valid_mem[upd_idx] <= 1'b1;
            end
        end
    end

    // tag and target only matter once valid is set
    always_ff @(posedge clk) begin
        if (!rst && !clr_en && alloc) begin
            tag_mem[upd_idx] <= upd_tag;
            tgt_mem[upd_idx] <= upd.target;
        end
    end

endmodule

// File: logic/bht_table.sv
// branch history table
// direct-mapped 2-bit saturating counters, combinational fetch and
// resolve lookups, one write port shared by init clear and training
module bht_table #(
    parameter int entries = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  bp_types_pkg::bp_pc_u       fetch_pc,
    input  logic                       ready,
    input  logic                       clr_en,
    input  logic [$clog2(entries)-1:0] clr_index,
    output logic                       pred_dir,
    bp_update_if.tbl                   upd
);
    import bp_cfg_pkg::*;

    localparam int idx_bits = $clog2(entries);

    ctr_t                ctr_mem [entries];  // one counter per entry
    logic [idx_bits-1:0] fetch_idx;
    logic [idx_bits-1:0] upd_idx;
    ctr_t                fetch_ctr;

    // one step toward the resolved direction, saturating at both ends
    function automatic ctr_t ctr_next(input ctr_t cur, input logic taken);
        ctr_t nxt;
        case (cur)
            ctr_sn:  nxt = taken ? ctr_wn : ctr_sn;
            ctr_wn:  nxt = taken ? ctr_wt : ctr_sn;
            ctr_wt:  nxt = taken ? ctr_st : ctr_wn;
            default: nxt = taken ? ctr_st : ctr_wt;  // ctr_st
        endcase
        return nxt;
    endfunction

    // index is the low bits of the word address
    assign fetch_idx = fetch_pc.fields.waddr[idx_bits-1:0];
    assign upd_idx   = upd.pc.fields.waddr[idx_bits-1:0];

    assign fetch_ctr = ctr_mem[fetch_idx];
    assign pred_dir  = ready & fetch_ctr[1];  // upper bit is direction

    // resolve side read-back
    assign upd.rd_ctr = ctr_mem[upd_idx];

    // clear has priority, though the two never overlap after init
    always_ff @(posedge clk) begin
        if (!rst) begin  // table frozen while reset is held
            if (clr_en) begin
                ctr_mem[clr_index] <= ctr_sn;
            end else if (upd.wr_en) begin
                ctr_mem[upd_idx] <= ctr_next(upd.rd_ctr, upd.taken);
            end
        end
    end

endmodule

// File: logic/bp_update_fsm.sv
// update sequencer
// four-phase req/ack toward the memory stage, reads back the tables,
// reports the mispredict and strobes one table write per update
module bp_update_fsm (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ready,
    input  logic                            upd_req,
    input  logic [bp_cfg_pkg::pc_width-1:0] upd_pc,
    input  logic                            upd_taken,
    input  logic [bp_cfg_pkg::pc_width-1:0] upd_target,
    output logic                            upd_ack,
    output logic                            upd_mispredict,
    bp_update_if.seq                        upd
);
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    upd_state_e          state;
    bp_pc_u              pc_q;
    logic                taken_q;
    logic [pc_width-1:0] target_q;
    ctr_t                rd_ctr_q;
    logic                rd_hit_q;
    logic [pc_width-1:0] rd_target_q;
    logic                start;
    logic                pred_taken;
    logic                mispredict;

    assign start = (state == st_idle) && ready && upd_req;  // no sampling during sweep

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= st_idle;
            upd_ack        <= 1'b0;
            upd_mispredict <= 1'b0;
        end else begin
            case (state)
                st_idle:  if (start) state <= st_read;
                st_read:  state <= st_write;
                st_write: begin
                    state          <= st_ack;
                    upd_ack        <= 1'b1;
                    upd_mispredict <= mispredict;  // held until next write
                end
                st_ack: begin
                    if (!upd_req) begin  // source released, close handshake
                        state   <= st_idle;
                        upd_ack <= 1'b0;
                    end
                end
                default:  state <= st_idle;
            endcase
        end
    end

    // request captured as the handshake opens, read-back at end of read
    always_ff @(posedge clk) begin
        if (start) begin
            pc_q.raw <= upd_pc;
            taken_q  <= upd_taken;
            target_q <= upd_target;
        end
        if (state == st_read) begin
            rd_ctr_q    <= upd.rd_ctr;
            rd_hit_q    <= upd.rd_hit;
            rd_target_q <= upd.rd_target;
        end
    end

    // what fetch would have predicted for this pc
    assign pred_taken = rd_ctr_q[1] & rd_hit_q;
    assign mispredict = (pred_taken != taken_q)
                      | (pred_taken & taken_q & (rd_target_q != target_q));  // wrong target

    assign upd.wr_en  = (state == st_write);
    assign upd.pc     = pc_q;
    assign upd.taken  = taken_q;
    assign upd.target = target_q;

endmodule

// File: logic/bp_init_sweep.sv
// table init sweep
// walks every table index once after reset, then raises ready
module bp_init_sweep #(
    parameter int entries = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       ready,
    output logic                       clr_en,
    output logic [$clog2(entries)-1:0] clr_index
);

    localparam int idx_bits = $clog2(entries);
    localparam logic [idx_bits-1:0] last_idx = idx_bits'(entries - 1);

    logic [idx_bits-1:0] idx_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx_q <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            if (idx_q == last_idx) begin
                ready <= 1'b1;  // last entry cleared this edge
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // one entry cleared per cycle until ready
    assign clr_en    = ~ready;
    assign clr_index = idx_q;

endmodule

// File: logic/bp_update_if.sv
// resolved-branch update bus
// sequencer drives the write fields, tables return the read-back
// for the same pc
interface bp_update_if;
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    logic                wr_en;      // single-cycle write strobe
    bp_pc_u              pc;         // resolve pc
    logic                taken;      // resolved direction
    logic [pc_width-1:0] target;     // resolved target

    ctr_t                rd_ctr;     // from bht
    logic                rd_hit;     // from btb
    logic [pc_width-1:0] rd_target;  // from btb

    modport seq (
        output wr_en, pc, taken, target,
        input  rd_ctr, rd_hit, rd_target
    );

    // each table drives only its own rd_ fields
    modport tbl (
        input  wr_en, pc, taken, target,
        output rd_ctr, rd_hit, rd_target
    );

endinterface

// File: logic/bp_types_pkg.sv
// branch predictor types
// pc word with a raw view and a word address / byte offset view,
// plus the update sequencer state encoding
package bp_types_pkg;

    localparam int waddr_bits = bp_cfg_pkg::pc_width - bp_cfg_pkg::offset_bits;

    // word address on top, byte offset in the low bits
    typedef struct packed {
        logic [waddr_bits-1:0]              waddr;
        logic [bp_cfg_pkg::offset_bits-1:0] offset;
    } bp_pc_s;

    // tables index off fields.waddr, top level drives raw
    typedef union packed {
        logic [bp_cfg_pkg::pc_width-1:0] raw;
        bp_pc_s                          fields;
    } bp_pc_u;

    typedef enum logic [1:0] {
        st_idle,   // waiting for upd_req
        st_read,   // table read-back settles
        st_write,  // wr_en strobe, mispredict registered
        st_ack     // upd_ack high until upd_req drops
    } upd_state_e;

endpackage

// File: logic/bp_cfg_pkg.sv
// branch predictor configuration
// pc sizing and the 2-bit saturating counter codes
package bp_cfg_pkg;

    localparam int pc_width    = 32;  // pc and target width
    localparam int offset_bits = 2;   // byte offset below word address

    // direction counter, upper bit is the predicted direction
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_sn = 2'd0;  // strongly not-taken
    localparam ctr_t ctr_wn = 2'd1;  // weakly not-taken
    localparam ctr_t ctr_wt = 2'd2;  // weakly taken
    localparam ctr_t ctr_st = 2'd3;  // strongly taken

endpackage
